// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_register_access_stall
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/stall_pkg.sv ====
package stall_pkg;

    // general register file of the x86 decode stage
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = 3;
    // esp / sp / ah slot
    localparam int SP_IDX    = 4;

    // operand kind codes as produced by the decoder tables
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_REG   = 3'd1,
        OP_SEG   = 3'd2,
        OP_MM    = 3'd3,
        OP_MODRM = 3'd4,
        OP_IMM   = 3'd5,
        OP_MEM   = 3'd6
    } op_kind_e;

    // only the byte code changes register mapping
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } size_e;

    typedef struct packed {
        logic [REG_IDX_W-1:0] idx;
        logic                 valid;
    } reg_access_t;

    // up to two reads per operand
    // op0_r0 sits in the top bits
    typedef struct packed {
        reg_access_t op0_r0;
        reg_access_t op0_r1;
        reg_access_t op1_r0;
        reg_access_t op1_r1;
    } src_set_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] idx;
        logic                 valid;
    } dest_t;

    typedef struct packed {
        op_kind_e             op0_kind;
        logic [REG_IDX_W-1:0] op0_reg;
        op_kind_e             op1_kind;
        logic [REG_IDX_W-1:0] op1_reg;
        logic [7:0]           mod_rm;
        logic [7:0]           sib;
        size_e                size;
        logic                 stack_op;
    } instr_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] idx;
        size_e                size;
        logic                 enable;
    } wb_t;

    // al/cl/dl/bl share a counter with ah/ch/dh/bh so byte access drops bit 2
    function automatic logic [REG_IDX_W-1:0] size_map(
        input logic [REG_IDX_W-1:0] idx,
        input size_e                size
    );
        logic [REG_IDX_W-1:0] mapped;
        mapped = idx;
        if (size == SIZE_BYTE) begin
            mapped[REG_IDX_W-1] = 1'b0;
        end
        return mapped;
    endfunction

endpackage

// ==== hw/operand_access_decode.sv ====
module operand_access_decode (
    input  stall_pkg::instr_t   instr,
    output stall_pkg::src_set_t srcs,
    output stall_pkg::dest_t    dest
);
    import stall_pkg::*;

    // mod r/m and sib fields
    logic [1:0]           mod;
    logic [REG_IDX_W-1:0] rm;
    logic [REG_IDX_W-1:0] sib_base;
    logic [REG_IDX_W-1:0] sib_index;

    // mod r/m addressing results shared by whichever operand is modrm
    logic                 mod_is_reg;
    logic                 disp_only;
    logic                 sib_index_used;
    logic [REG_IDX_W-1:0] modrm_r0_idx;

    assign mod       = instr.mod_rm[7:6];
    assign rm        = instr.mod_rm[2:0];
    assign sib_base  = instr.sib[2:0];
    assign sib_index = instr.sib[5:3];

    assign mod_is_reg = (mod == 2'b11);
    // mod 00 rm 101 is a plain disp32 with no base register read
    assign disp_only  = (mod == 2'b00) && (rm == 3'b101);
    // index 100 in the sib byte means no index register
    assign sib_index_used = !mod_is_reg && (rm == 3'b100) && (sib_index != 3'b100);

    always_comb begin
        if (mod_is_reg) begin
            // in register form rm names a sized register
            modrm_r0_idx = size_map(rm, instr.size);
        end else if (rm == 3'b100) begin
            modrm_r0_idx = sib_base;
        end else begin
            modrm_r0_idx = rm;
        end
    end

    // first register read of one operand
    function automatic reg_access_t first_read(
        input op_kind_e             kind,
        input logic [REG_IDX_W-1:0] op_reg,
        input size_e                size,
        input logic [REG_IDX_W-1:0] mr_idx,
        input logic                 mr_no_base
    );
        reg_access_t rd;
        rd = '0;
        case (kind)
            OP_REG: begin
                rd.valid = 1'b1;
                rd.idx   = size_map(op_reg, size);
            end
            // address held in a full width register
            OP_MEM: begin
                rd.valid = 1'b1;
                rd.idx   = op_reg;
            end
            OP_MODRM: begin
                rd.valid = !mr_no_base;
                rd.idx   = mr_idx;
            end
            // segment, mm, immediate and none touch no general register
            default: begin
                rd = '0;
            end
        endcase
        return rd;
    endfunction

    // second read only comes from a sib index
    function automatic reg_access_t second_read(
        input op_kind_e             kind,
        input logic                 idx_used,
        input logic [REG_IDX_W-1:0] idx
    );
        reg_access_t rd;
        rd.valid = (kind == OP_MODRM) && idx_used;
        rd.idx   = idx;
        return rd;
    endfunction

    always_comb begin
        srcs.op0_r0 = first_read(instr.op0_kind, instr.op0_reg, instr.size,
                                 modrm_r0_idx, disp_only);
        srcs.op0_r1 = second_read(instr.op0_kind, sib_index_used, sib_index);
        srcs.op1_r0 = first_read(instr.op1_kind, instr.op1_reg, instr.size,
                                 modrm_r0_idx, disp_only);
        srcs.op1_r1 = second_read(instr.op1_kind, sib_index_used, sib_index);
    end

    // op0 writes a register when it is a register or a register-form mod r/m
    always_comb begin
        dest = '0;
        if (instr.op0_kind == OP_REG) begin
            dest.valid = 1'b1;
            dest.idx   = size_map(instr.op0_reg, instr.size);
        end else if ((instr.op0_kind == OP_MODRM) && mod_is_reg) begin
            dest.valid = 1'b1;
            dest.idx   = size_map(rm, instr.size);
        end
    end

endmodule

// ==== hw/register_access_stall.sv ====
module register_access_stall #(
    parameter int CNT_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  stall_pkg::instr_t instr,
    input  stall_pkg::wb_t    wb,
    input  logic              next_stage_ready,
    output logic              is_stall
);
    import stall_pkg::*;

    src_set_t                           srcs;
    dest_t                              dest;
    logic [NUM_REGS-1:0][CNT_W-1:0]     counts;

    // which registers the instruction reads and writes
    operand_access_decode u_decode (
        .instr (instr),
        .srcs  (srcs),
        .dest  (dest)
    );

    // same-cycle stall from the current counter values
    hazard_check #(
        .CNT_W (CNT_W)
    ) u_hazard (
        .srcs     (srcs),
        .stack_op (instr.stack_op),
        .counts   (counts),
        .is_stall (is_stall)
    );

    // counters move on issue and writeback
    scoreboard_table #(
        .CNT_W (CNT_W)
    ) u_table (
        .clk              (clk),
        .rst_n            (rst_n),
        .dest             (dest),
        .wb               (wb),
        .next_stage_ready (next_stage_ready),
        .is_stall         (is_stall),
        .counts           (counts)
    );

endmodule

// ==== scoreboard/hazard_check.sv ====
module hazard_check #(
    parameter int CNT_W = 4
) (
    input  stall_pkg::src_set_t                           srcs,
    input  logic                                          stack_op,
    input  logic [stall_pkg::NUM_REGS-1:0][CNT_W-1:0]     counts,
    output logic                                          is_stall
);
    import stall_pkg::*;

    localparam int NUM_SRCS = 4;

    reg_access_t [NUM_SRCS-1:0] src_list;
    logic        [NUM_SRCS-1:0] src_hit;
    logic                       sp_busy;
    logic                       stack_stall;

    // flatten the source set so each read gets the same check
    assign src_list[0] = srcs.op0_r0;
    assign src_list[1] = srcs.op0_r1;
    assign src_list[2] = srcs.op1_r0;
    assign src_list[3] = srcs.op1_r1;

    // a read hits when an older instruction still owes a writeback to it
    always_comb begin
        for (int i = 0; i < NUM_SRCS; i++) begin
            src_hit[i] = src_list[i].valid && (counts[src_list[i].idx] != '0);
        end
    end

    // push/pop/call/ret use sp implicitly
    assign sp_busy     = (counts[SP_IDX] != '0);
    assign stack_stall = stack_op && sp_busy;

    assign is_stall = (|src_hit) || stack_stall;

endmodule

// ==== scoreboard/scoreboard_table.sv ====
module scoreboard_table #(
    parameter int CNT_W = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  stall_pkg::dest_t                          dest,
    input  stall_pkg::wb_t                            wb,
    input  logic                                      next_stage_ready,
    input  logic                                      is_stall,
    output logic [stall_pkg::NUM_REGS-1:0][CNT_W-1:0] counts
);
    import stall_pkg::*;

    logic                 issue;
    logic [REG_IDX_W-1:0] wb_idx;
    logic [NUM_REGS-1:0]  inc_hit;
    logic [NUM_REGS-1:0]  dec_hit;

    // the instruction only leaves decode when downstream takes it and no hazard holds it
    assign issue = next_stage_ready && !is_stall;

    // writeback names the register at its access size so ah retires counter 0
    assign wb_idx = size_map(wb.idx, wb.size);

    for (genvar r = 0; r < NUM_REGS; r++) begin : g_cnt

        assign inc_hit[r] = issue && dest.valid && (dest.idx == REG_IDX_W'(r));
        assign dec_hit[r] = wb.enable && (wb_idx == REG_IDX_W'(r));

        // one pending-write counter per register
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                counts[r] <= '0;
            end else begin
                case ({inc_hit[r], dec_hit[r]})
                    2'b10: begin
                        counts[r] <= counts[r] + 1'b1;
                    end
                    2'b01: begin
                        counts[r] <= counts[r] - 1'b1;
                    end
                    // issue and retire together cancel out
                    default: begin
                        counts[r] <= counts[r];
                    end
                endcase
            end
        end

    end

endmodule

// ==== sim/register_access_stall_checker.sv ====
module register_access_stall_checker #(
    parameter int CNT_W = 4
) (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic [stall_pkg::NUM_REGS-1:0]            inc_hit,
    input logic [stall_pkg::NUM_REGS-1:0]            dec_hit,
    input logic [stall_pkg::NUM_REGS-1:0][CNT_W-1:0] counts,
    input logic                                      is_stall
);
    import stall_pkg::*;

    for (genvar r = 0; r < NUM_REGS; r++) begin : g_reg
        // a writeback with nothing pending would wrap the counter
        a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
            (dec_hit[r] && !inc_hit[r]) |-> (counts[r] != '0))
            else $error("counter %0d decremented at zero", r);

        a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
            (inc_hit[r] && !dec_hit[r]) |-> (counts[r] != '1))
            else $error("counter %0d incremented when full", r);
    end

    a_stall_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(is_stall))
        else $error("is_stall unknown after reset");

endmodule

bind scoreboard_table register_access_stall_checker #(
    .CNT_W (CNT_W)
) u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .inc_hit  (inc_hit),
    .dec_hit  (dec_hit),
    .counts   (counts),
    .is_stall (is_stall)
);

// ==== sim/tb_register_access_stall.sv ====
module tb_register_access_stall;
    import stall_pkg::*;

    localparam int CNT_W       = 4;
    localparam int DIR_CYCLES  = 60;
    localparam int RAND_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    instr_t      instr;
    wb_t         wb;
    logic        next_stage_ready;
    logic        is_stall;

    // model counters and the destinations that still owe a writeback
    int          model_cnt [NUM_REGS];
    logic [2:0]  pending [$];
    logic [31:0] lcg_state;
    string       test_name;
    string       check_name;
    int          dir_exp;
    bit          checking;
    int          n_checks;
    int          n_errors;

    register_access_stall #(
        .CNT_W (CNT_W)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr            (instr),
        .wb               (wb),
        .next_stage_ready (next_stage_ready),
        .is_stall         (is_stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte access to 4..7 names the high byte of 0..3
    function automatic logic [2:0] byte_map(logic [2:0] idx, size_e size);
        return (size == SIZE_BYTE) ? {1'b0, idx[1:0]} : idx;
    endfunction

    function automatic bit busy(logic [2:0] idx);
        return model_cnt[idx] != 0;
    endfunction

    // true when some register read of this operand waits on a pending write
    function automatic bit operand_hits(op_kind_e kind, logic [2:0] rg, instr_t in);
        logic [2:0] rm;
        logic [2:0] base;
        logic [2:0] sidx;
        rm   = in.mod_rm[2:0];
        base = in.sib[2:0];
        sidx = in.sib[5:3];
        case (kind)
            OP_REG:  return busy(byte_map(rg, in.size));
            OP_MEM:  return busy(rg);
            OP_MODRM: begin
                if (in.mod_rm[7:6] == 2'b11) begin
                    return busy(byte_map(rm, in.size));
                end else if (in.mod_rm[7:6] == 2'b00 && rm == 3'b101) begin
                    // disp32 has no register behind it
                    return 1'b0;
                end else if (rm == 3'b100) begin
                    return busy(base) || (sidx != 3'b100 && busy(sidx));
                end
                return busy(rm);
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic bit expected_stall(instr_t in);
        return operand_hits(in.op0_kind, in.op0_reg, in) ||
               operand_hits(in.op1_kind, in.op1_reg, in) ||
               (in.stack_op && busy(3'(SP_IDX)));
    endfunction

    // {valid, idx} of the register op0 writes
    function automatic logic [3:0] expected_dest(instr_t in);
        if (in.op0_kind == OP_REG) begin
            return {1'b1, byte_map(in.op0_reg, in.size)};
        end else if (in.op0_kind == OP_MODRM && in.mod_rm[7:6] == 2'b11) begin
            return {1'b1, byte_map(in.mod_rm[2:0], in.size)};
        end
        return 4'b0;
    endfunction

    // issue and writeback rule on the inputs seen at this edge
    task automatic update_model();
        logic [3:0] d;
        logic [2:0] w;
        bit         writes;
        bit         inc;
        bit         dec;
        d      = expected_dest(instr);
        w      = byte_map(wb.idx, wb.size);
        writes = next_stage_ready && !expected_stall(instr) && d[3];
        for (int r = 0; r < NUM_REGS; r++) begin
            inc = writes && (d[2:0] == 3'(r));
            dec = wb.enable && (w == 3'(r));
            if (inc && !dec) begin
                model_cnt[r]++;
            end else if (dec && !inc) begin
                model_cnt[r]--;
            end
        end
        if (writes) begin
            pending.push_back(d[2:0]);
        end
    endtask

    // update the model on the edge and then drive the next inputs
    task automatic step(instr_t in, wb_t w, logic rdy, int exp);
        @(posedge clk);
        update_model();
        check_name = test_name;
        dir_exp    = exp;
        instr            <= in;
        wb               <= w;
        next_stage_ready <= rdy;
    endtask

    function automatic instr_t reg_write(logic [2:0] idx, size_e size);
        instr_t in;
        in          = '0;
        in.op0_kind = OP_REG;
        in.op0_reg  = idx;
        in.size     = size;
        return in;
    endfunction

    function automatic instr_t reg_read(logic [2:0] idx);
        instr_t in;
        in          = '0;
        in.op1_kind = OP_REG;
        in.op1_reg  = idx;
        in.size     = SIZE_DWORD;
        return in;
    endfunction

    function automatic instr_t modrm_read(logic [7:0] mr, logic [7:0] sb);
        instr_t in;
        in          = '0;
        in.op1_kind = OP_MODRM;
        in.mod_rm   = mr;
        in.sib      = sb;
        in.size     = SIZE_DWORD;
        return in;
    endfunction

    function automatic wb_t make_wb(logic [2:0] idx, size_e size);
        wb_t w;
        w.idx    = idx;
        w.size   = size;
        w.enable = 1'b1;
        return w;
    endfunction

    function automatic instr_t random_instr();
        instr_t in;
        in.op0_kind = op_kind_e'(3'((lcg_next() >> 16) % 7));
        in.op0_reg  = 3'(lcg_next() >> 16);
        in.op1_kind = op_kind_e'(3'((lcg_next() >> 16) % 7));
        in.op1_reg  = 3'(lcg_next() >> 16);
        in.mod_rm   = 8'(lcg_next() >> 16);
        in.sib      = 8'(lcg_next() >> 12);
        in.size     = size_e'(2'((lcg_next() >> 16) % 3));
        in.stack_op = ((lcg_next() >> 16) % 8) == 0;
        return in;
    endfunction

    // sampled half a cycle after the inputs move
    always @(negedge clk) begin : compare_stall
        bit want;
        if (checking) begin
            want = expected_stall(instr);
            n_checks++;
            if (is_stall !== want) begin
                n_errors++;
                $display("error %s: expected %0b actual %0b", check_name, want, is_stall);
            end
            if (dir_exp >= 0 && is_stall !== dir_exp[0]) begin
                n_errors++;
                $display("error %s: expected %0d actual %0b", check_name, dir_exp, is_stall);
            end
        end
    end

    initial begin
        #((DIR_CYCLES + RAND_CYCLES) * 10 * 2);
        $display("timeout, the tests did not finish in the expected time");
        $display("checks %0d errors %0d", n_checks, n_errors);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        instr_t      idle;
        instr_t      t;
        wb_t         nowb;
        wb_t         rwb;
        logic [31:0] r;
        int          k;
        logic [2:0]  widx;
        lcg_state        = 32'h1b45;
        checking         = 1'b0;
        dir_exp          = -1;
        n_checks         = 0;
        n_errors         = 0;
        test_name        = "reset";
        idle             = '0;
        nowb             = '0;
        rst_n            <= 1'b0;
        instr            <= '0;
        wb               <= '0;
        next_stage_ready <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n    <= 1'b1;
        checking = 1'b1;

        // with all counters clear nothing can stall
        test_name = "reset_quiet";
        repeat (8) begin
            step(random_instr(), nowb, 1'b0, 0);
        end

        test_name = "raw";
        step(reg_write(3'd2, SIZE_DWORD), nowb, 1'b1, 0);
        step(reg_read(3'd2), nowb, 1'b1, 1);
        step(reg_read(3'd2), make_wb(3'd2, SIZE_DWORD), 1'b1, 1);
        step(reg_read(3'd2), nowb, 1'b1, 0);
        // second write to r3 is held until the first retires
        step(reg_write(3'd3, SIZE_DWORD), nowb, 1'b1, 0);
        step(reg_write(3'd3, SIZE_DWORD), make_wb(3'd3, SIZE_DWORD), 1'b1, 1);
        step(reg_write(3'd3, SIZE_DWORD), nowb, 1'b1, 0);
        step(reg_read(3'd3), make_wb(3'd3, SIZE_DWORD), 1'b1, 1);
        step(reg_read(3'd3), nowb, 1'b1, 0);
        // issue and writeback of r6 on one edge cancel
        step(reg_write(3'd6, SIZE_DWORD), make_wb(3'd6, SIZE_DWORD), 1'b1, 0);
        step(reg_read(3'd6), nowb, 1'b1, 0);

        test_name = "modrm";
        step(reg_write(3'd3, SIZE_DWORD), nowb, 1'b1, 0);
        step(reg_write(3'd5, SIZE_DWORD), nowb, 1'b1, 0);
        step(modrm_read(8'b00_000_011, 8'h00), nowb, 1'b1, 1);
        step(modrm_read(8'b10_000_100, 8'b00_000_011), nowb, 1'b1, 1);
        step(modrm_read(8'b01_000_100, 8'b00_011_000), nowb, 1'b1, 1);
        step(modrm_read(8'b01_000_100, 8'b00_100_000), nowb, 1'b1, 0);
        step(modrm_read(8'b00_000_101, 8'h00), nowb, 1'b1, 0);
        step(modrm_read(8'b01_000_101, 8'h00), nowb, 1'b1, 1);
        t          = reg_read(3'd3);
        t.op1_kind = OP_SEG;
        t.op0_kind = OP_IMM;
        t.op0_reg  = 3'd5;
        step(t, nowb, 1'b1, 0);
        step(idle, make_wb(3'd3, SIZE_DWORD), 1'b1, 0);
        step(idle, make_wb(3'd5, SIZE_DWORD), 1'b1, 0);

        // ch lands on the ecx counter
        test_name = "byte_alias";
        step(reg_write(3'd5, SIZE_BYTE), nowb, 1'b1, 0);
        step(reg_read(3'd1), nowb, 1'b1, 1);
        step(reg_read(3'd1), make_wb(3'd5, SIZE_BYTE), 1'b1, 1);
        step(reg_read(3'd1), nowb, 1'b1, 0);

        test_name  = "stack";
        t          = idle;
        t.stack_op = 1'b1;
        step(reg_write(3'd4, SIZE_DWORD), nowb, 1'b1, 0);
        step(t, nowb, 1'b1, 1);
        step(t, make_wb(3'd4, SIZE_DWORD), 1'b1, 1);
        step(t, nowb, 1'b1, 0);
        test_name = "backpressure";
        repeat (3) begin
            step(reg_write(3'd6, SIZE_DWORD), nowb, 1'b0, 0);
        end
        step(reg_read(3'd6), nowb, 1'b1, 0);

        // every directed write has already been retired by hand
        pending.delete();

        test_name = "random";
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r   = lcg_next();
            rwb = '0;
            // retire one of the outstanding writes
            if (pending.size() > 0 && r[21]) begin
                k    = int'(r[31:24]) % pending.size();
                widx = pending[k];
                pending.delete(k);
                rwb.enable = 1'b1;
                if (!widx[2] && r[22]) begin
                    rwb.idx  = {1'b1, widx[1:0]};
                    rwb.size = SIZE_BYTE;
                end else begin
                    rwb.idx  = widx;
                    rwb.size = r[23] ? SIZE_DWORD : SIZE_WORD;
                end
            end
            step(random_instr(), rwb, r[19:18] != 2'b00, -1);
        end
        step(idle, nowb, 1'b0, -1);
        @(posedge clk);
        checking = 1'b0;

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/stall_pkg.sv
hw/operand_access_decode.sv
scoreboard/hazard_check.sv
scoreboard/scoreboard_table.sv
hw/register_access_stall.sv
sim/register_access_stall_checker.sv
sim/tb_register_access_stall.sv
